/* bank_capture.f */
hdl/bank_capture_pkg.sv
hdl/bank_port_if.sv
hdl/bank_fifo.sv
hdl/sample_packer.sv
hdl/bank_reader.sv
hdl/bank_capture_top.sv
dv/tb_bank_capture.sv

/* dv/tb_bank_capture.sv */
`timescale 1ns/1ps

module tb_bank_capture;

    localparam int ADDR_W       = 4;
    localparam int SW           = bank_capture_pkg::sample_w;
    localparam int WW           = bank_capture_pkg::word_w;
    localparam int W_PERIOD     = 10;
    localparam int R_PERIOD     = 8;
    localparam int PHASES       = 5;
    localparam int PHASE_CYCLES = 400;
    localparam int SEED         = 32'h64d78f8a;

    logic          w_clk;
    logic          r_clk;
    logic          fullish;
    logic          sample_valid;
    logic [SW-1:0] sample_data;
    logic          overflow;
    logic          drain_en;
    logic          out_valid;
    logic [WW-1:0] out_data;
    logic          bank_start;

    // Packer model and scoreboard
    logic [WW-1:0] expected_q [$];
    logic [WW-1:0] exp_word;
    logic [WW-1:0] pair_word;
    logic [SW-1:0] low_byte;
    logic          have_low;
    logic          pair_done;
    logic          lossless;
    int            accepted;
    int            dropped;
    int            out_count;
    int            fill_base;

    bank_capture_top #(
        .ADDR_W (ADDR_W)
    ) i_dut (
        .w_clk        (w_clk),
        .r_clk        (r_clk),
        .fullish      (fullish),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .overflow     (overflow),
        .drain_en     (drain_en),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .bank_start   (bank_start)
    );

    initial begin
        w_clk = 1'b0;
        forever #(W_PERIOD / 2) w_clk = ~w_clk;
    end

    initial begin
        r_clk = 1'b0;
        forever #(R_PERIOD / 2) r_clk = ~r_clk;
    end

    task automatic mismatch(input string test, input logic [31:0] expected,
                            input logic [31:0] actual);
        $display("Fail %s: expected %0h, actual %0h", test, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "check %s failed", test);
    endtask

    task automatic abort_run(input string reason);
        $display("Error: %s", reason);
        $display("TEST FAILED");
        $fatal(1, "%s", reason);
    endtask

    // ======================================================================
    // Stimulus on the w_clk side
    // ======================================================================
    task automatic drive_sample(input logic valid);
        @(posedge w_clk);
        #1;
        // Pair taken on this edge is written on the next one, if ready holds
        if (pair_done) begin
            if (i_dut.wr_port.ready) begin
                expected_q.push_back(pair_word);
                accepted++;
            end else begin
                dropped++;
            end
            pair_done = 1'b0;
        end
        sample_valid = valid;
        sample_data  = valid ? SW'($urandom) : '0;
        if (valid) begin
            if (have_low) begin
                pair_word = {sample_data, low_byte};
                pair_done = 1'b1;
            end else begin
                low_byte = sample_data;
            end
            have_low = !have_low;
        end
    endtask

    task automatic stream_samples(input int count, input int gap);
        for (int i = 0; i < count; i++) begin
            drive_sample(1'b1);
            repeat (gap) drive_sample(1'b0);
        end
        repeat (2) drive_sample(1'b0);
    endtask

    task automatic set_drain(input logic en);
        @(posedge r_clk);
        #1;
        drain_en = en;
    endtask

    task automatic wait_drained();
        while (expected_q.size() != 0) begin
            @(posedge r_clk);
        end
        // Room for a stray extra word to show up
        repeat (20) @(posedge r_clk);
    endtask

    task automatic apply_reset();
        @(posedge r_clk);
        #1;
        fullish = 1'b1;
        expected_q.delete();
        have_low  = 1'b0;
        pair_done = 1'b0;
        repeat (5) @(posedge r_clk);
        #1;
        fullish = 1'b0;
        // Each domain releases two edges of its own clock later
        repeat (4) @(posedge w_clk);
        #1;
    endtask

    // ======================================================================
    // Checks
    // ======================================================================
    always @(negedge r_clk) begin
        if (fullish) begin
            out_count = 0;
        end else if (out_valid) begin
            if (expected_q.size() == 0) begin
                abort_run("output word arrived with no expected word left");
            end else begin
                exp_word = expected_q.pop_front();
                assert (out_data == exp_word)
                    else mismatch("order", 32'(exp_word), 32'(out_data));
                assert (bank_start == (out_count % 8 == 0))
                    else mismatch("bank_marking", 32'(out_count % 8 == 0), 32'(bank_start));
                out_count++;
            end
        end else begin
            assert (!bank_start) else mismatch("bank_marking_idle", 32'd0, 32'(bank_start));
        end
    end

    a_overflow_sticky: assert property (@(posedge w_clk) disable iff (fullish)
        overflow |=> overflow)
        else mismatch("overflow_sticky", 32'd1, 32'(overflow));

    a_lossless: assert property (@(posedge w_clk) disable iff (fullish)
        lossless |-> !overflow)
        else mismatch("lossless", 32'd0, 32'(overflow));

    // Watchdog, 400 w_clk cycles per phase
    initial begin
        #(PHASES * PHASE_CYCLES * W_PERIOD);
        $display("Error: watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    // ======================================================================
    // Test phases
    // ======================================================================
    initial begin
        void'($urandom(SEED));
        fullish      = 1'b1;
        sample_valid = 1'b0;
        sample_data  = '0;
        drain_en     = 1'b0;
        lossless     = 1'b0;
        have_low     = 1'b0;
        low_byte     = '0;
        pair_done    = 1'b0;
        pair_word    = '0;
        accepted     = 0;
        dropped      = 0;
        fill_base    = 0;
        apply_reset();

        // Streaming with one sample in three, three full banks
        set_drain(1'b1);
        lossless = 1'b1;
        stream_samples(48, 2);
        wait_drained();
        lossless = 1'b0;
        assert (dropped == 0) else mismatch("lossless_drops", 32'd0, 32'(dropped));

        // Fill with the reader held off
        set_drain(1'b0);
        fill_base = accepted;
        stream_samples(40, 0);
        assert (overflow) else mismatch("overflow_set", 32'd1, 32'(overflow));
        assert (dropped > 0) else mismatch("overflow_drops", 32'd1, 32'(dropped));
        assert (accepted - fill_base <= 16)
            else mismatch("overflow_accepted", 32'd16, 32'(accepted - fill_base));
        set_drain(1'b1);
        wait_drained();

        // Reset while words are still in flight
        stream_samples(20, 0);
        apply_reset();
        assert (!out_valid) else mismatch("reset_out_valid", 32'd0, 32'(out_valid));
        assert (!bank_start) else mismatch("reset_bank_start", 32'd0, 32'(bank_start));
        assert (!overflow) else mismatch("reset_overflow", 32'd0, 32'(overflow));

        // Numbering starts over after reset
        set_drain(1'b1);
        lossless = 1'b1;
        stream_samples(48, 2);
        wait_drained();
        lossless = 1'b0;

        $display("TEST OK");
        $finish;
    end

endmodule

/* hdl/bank_capture_pkg.sv */
package bank_capture_pkg;

    // Datapath widths
    localparam int unsigned sample_w = 8;
    localparam int unsigned word_w   = 2 * sample_w;

    // Quadrant is the top two address bits
    localparam int unsigned quad_w = 2;

    // Write quadrant minus read quadrant, modulo 4
    localparam logic [quad_w-1:0] quad_ahead  = quad_w'(1);
    localparam logic [quad_w-1:0] quad_behind = {quad_w{1'b1}};

    typedef enum logic {
        rd_idle,
        rd_burst
    } rd_state_t;

    function automatic logic [quad_w-1:0] quad_to_gray(input logic [quad_w-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    function automatic logic [quad_w-1:0] quad_from_gray(input logic [quad_w-1:0] gray);
        logic [quad_w-1:0] bin;
        bin[quad_w-1] = gray[quad_w-1];
        for (int i = quad_w - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

/* hdl/bank_capture_top.sv */
`timescale 1ns/1ps

module bank_capture_top #(
    parameter int ADDR_W = 4
) (
    input  logic                                  w_clk,
    input  logic                                  r_clk,
    input  logic                                  fullish,
    input  logic                                  sample_valid,
    input  logic [bank_capture_pkg::sample_w-1:0] sample_data,
    output logic                                  overflow,
    input  logic                                  drain_en,
    output logic                                  out_valid,
    output logic [bank_capture_pkg::word_w-1:0]   out_data,
    output logic                                  bank_start
);

    // FIFO ports, write side in w_clk and read side in r_clk
    bank_port_if #(.ADDR_W(ADDR_W)) wr_port ();
    bank_port_if #(.ADDR_W(ADDR_W)) rd_port ();

    sample_packer i_sample_packer (
        .w_clk        (w_clk),
        .fullish      (fullish),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .wr           (wr_port.wr_src),
        .overflow     (overflow)
    );

    bank_fifo #(
        .ADDR_W (ADDR_W)
    ) i_bank_fifo (
        .w_clk   (w_clk),
        .r_clk   (r_clk),
        .fullish (fullish),
        .wr      (wr_port.wr_fifo),
        .rd      (rd_port.rd_fifo)
    );

    bank_reader i_bank_reader (
        .r_clk      (r_clk),
        .fullish    (fullish),
        .drain_en   (drain_en),
        .rd         (rd_port.rd_sink),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .bank_start (bank_start)
    );

endmodule

/* hdl/bank_fifo.sv */
`timescale 1ns/1ps

module bank_fifo #(
    parameter int ADDR_W = 4
) (
    input  logic         w_clk,
    input  logic         r_clk,
    input  logic         fullish,
    bank_port_if.wr_fifo wr,
    bank_port_if.rd_fifo rd
);

    localparam int unsigned depth = 1 << ADDR_W;
    localparam int unsigned qw    = bank_capture_pkg::quad_w;

    logic [bank_capture_pkg::word_w-1:0] mem [depth];

    // Direction flag, high while filling, low while emptying
    logic dir;

    // ======================================================================
    // Reset synchronizers
    // ======================================================================
    logic [1:0] w_rst_sync;
    logic [1:0] r_rst_sync;
    logic       w_rst;
    logic       r_rst;

    always_ff @(posedge w_clk or posedge fullish) begin
        if (fullish) begin
            w_rst_sync <= 2'b11;
        end else begin
            w_rst_sync <= {w_rst_sync[0], 1'b0};
        end
    end

    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            r_rst_sync <= 2'b11;
        end else begin
            r_rst_sync <= {r_rst_sync[0], 1'b0};
        end
    end

    assign w_rst = w_rst_sync[1];
    assign r_rst = r_rst_sync[1];

    // ======================================================================
    // Write domain
    // ======================================================================
    logic [ADDR_W-1:0] w_addr;
    logic [ADDR_W-1:0] w_addr_nxt;
    logic              w_we;
    logic [1:0]        w_rbank_sync;
    logic [1:0]        w_dir_sync;
    logic [qw-1:0]     w_quad_gray;
    logic              w_ready_q;

    assign w_we       = wr.trigger && w_ready_q;
    assign w_addr_nxt = w_addr + ADDR_W'(w_we);
    assign wr.ready   = w_ready_q;
    assign wr.bank    = w_addr[ADDR_W-1];

    always_ff @(posedge w_clk or posedge w_rst) begin
        if (w_rst) begin
            w_addr       <= '0;
            w_rbank_sync <= '0;
            w_dir_sync   <= '0;
            w_quad_gray  <= '0;
            w_ready_q    <= 1'b0;
        end else begin
            w_addr       <= w_addr_nxt;
            w_rbank_sync <= {w_rbank_sync[0], rd.bank};
            w_dir_sync   <= {w_dir_sync[0], dir};
            w_quad_gray  <= bank_capture_pkg::quad_to_gray(w_addr_nxt[ADDR_W-1 -: qw]);
            // Other bank is free, or anywhere while emptying
            w_ready_q    <= (w_addr_nxt[ADDR_W-1] != w_rbank_sync[1]) || !w_dir_sync[1];
        end
    end

    always_ff @(posedge w_clk) begin
        if (w_we) begin
            mem[w_addr] <= wr.data;
        end
    end

    // ======================================================================
    // Read domain and direction flag
    // ======================================================================
    logic [ADDR_W-1:0] r_addr;
    logic [ADDR_W-1:0] r_addr_nxt;
    logic              r_re;
    logic [1:0]        r_wbank_sync;
    logic [qw-1:0]     r_wquad_s1;
    logic [qw-1:0]     r_wquad_s2;
    logic [qw-1:0]     quad_dist;
    logic              near_full;
    logic              near_empty;
    logic              dir_nxt;
    logic              r_ready_q;

    assign r_re       = rd.trigger && r_ready_q;
    assign r_addr_nxt = r_addr + ADDR_W'(r_re);
    assign rd.ready   = r_ready_q;
    assign rd.bank    = r_addr[ADDR_W-1];
    assign rd.data    = mem[r_addr];

    // Writer one quadrant behind the reader means it is about to catch up
    assign quad_dist  = bank_capture_pkg::quad_from_gray(r_wquad_s2) - r_addr[ADDR_W-1 -: qw];
    assign near_full  = (quad_dist == bank_capture_pkg::quad_behind);
    assign near_empty = (quad_dist == bank_capture_pkg::quad_ahead);
    assign dir_nxt    = near_full ? 1'b1 : (near_empty ? 1'b0 : dir);

    always_ff @(posedge r_clk or posedge r_rst) begin
        if (r_rst) begin
            r_addr       <= '0;
            r_wbank_sync <= '0;
            r_wquad_s1   <= '0;
            r_wquad_s2   <= '0;
            dir          <= 1'b0;
            r_ready_q    <= 1'b0;
        end else begin
            r_addr       <= r_addr_nxt;
            r_wbank_sync <= {r_wbank_sync[0], wr.bank};
            r_wquad_s1   <= w_quad_gray;
            r_wquad_s2   <= r_wquad_s1;
            dir          <= dir_nxt;
            // Mirror of the write rule, anywhere while filling
            r_ready_q    <= (r_addr_nxt[ADDR_W-1] != r_wbank_sync[1]) || dir_nxt;
        end
    end

    // A blocked write leaves the write address in place
    a_no_blocked_write: assert property (@(posedge w_clk) disable iff (w_rst)
        wr.trigger && !wr.ready |=> $stable(w_addr))
        else $error("bank_fifo: write address moved on a blocked write");

    a_no_blocked_read: assert property (@(posedge r_clk) disable iff (r_rst)
        rd.trigger && !rd.ready |=> $stable(r_addr))
        else $error("bank_fifo: read address moved on a blocked read");

    a_dir_exclusive: assert property (@(posedge r_clk) disable iff (r_rst)
        !(near_full && near_empty))
        else $error("bank_fifo: near_full and near_empty both set");

endmodule

/* hdl/bank_port_if.sv */
`timescale 1ns/1ps

interface bank_port_if #(
    parameter int ADDR_W = 4
);

    logic                                ready;
    logic                                trigger;
    logic [bank_capture_pkg::word_w-1:0] data;
    logic                                bank;

    // Two banks of at least two quadrants each
    if (ADDR_W < 2) begin : g_addr_check
        $error("bank_port_if: ADDR_W must be at least 2");
    end

    // Sample packer side of the write port
    modport wr_src (
        input  ready,
        input  bank,
        output trigger,
        output data
    );

    modport wr_fifo (
        output ready,
        output bank,
        input  trigger,
        input  data
    );

    modport rd_fifo (
        output ready,
        output data,
        output bank,
        input  trigger
    );

    // Reader side, data is valid whenever ready is high
    modport rd_sink (
        input  ready,
        input  data,
        input  bank,
        output trigger
    );

endinterface

/* hdl/bank_reader.sv */
`timescale 1ns/1ps

module bank_reader (
    input  logic                                r_clk,
    input  logic                                fullish,
    input  logic                                drain_en,
    bank_port_if.rd_sink                        rd,
    output logic                                out_valid,
    output logic [bank_capture_pkg::word_w-1:0] out_data,
    output logic                                bank_start
);

    bank_capture_pkg::rd_state_t state;
    bank_capture_pkg::rd_state_t state_nxt;

    logic xfer;
    logic first_word;
    logic last_bank;

    // Stop at once when drain_en falls
    assign rd.trigger = (state == bank_capture_pkg::rd_burst) && drain_en;
    assign xfer       = rd.trigger && rd.ready;

    // ======================================================================
    // Drain FSM
    // ======================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            bank_capture_pkg::rd_idle: begin
                if (drain_en && rd.ready) begin
                    state_nxt = bank_capture_pkg::rd_burst;
                end
            end
            bank_capture_pkg::rd_burst: begin
                if (!(drain_en && rd.ready)) begin
                    state_nxt = bank_capture_pkg::rd_idle;
                end
            end
            default: state_nxt = bank_capture_pkg::rd_idle;
        endcase
    end

    always_ff @(posedge r_clk or posedge fullish) begin
        if (fullish) begin
            state      <= bank_capture_pkg::rd_idle;
            out_valid  <= 1'b0;
            bank_start <= 1'b0;
            first_word <= 1'b1;
            last_bank  <= 1'b0;
        end else begin
            state      <= state_nxt;
            out_valid  <= xfer;
            // New bank, or very first word since reset
            bank_start <= xfer && (first_word || (rd.bank != last_bank));
            if (xfer) begin
                first_word <= 1'b0;
                last_bank  <= rd.bank;
            end
        end
    end

    always_ff @(posedge r_clk) begin
        if (xfer) begin
            out_data <= rd.data;
        end
    end

    // Each output word comes from a transfer on the edge before
    a_valid_after_xfer: assert property (@(posedge r_clk) disable iff (fullish)
        out_valid |-> $past(rd.trigger && rd.ready))
        else $error("bank_reader: out_valid without a read transfer");

endmodule

/* hdl/sample_packer.sv */
`timescale 1ns/1ps

module sample_packer (
    input  logic                                  w_clk,
    input  logic                                  fullish,
    input  logic                                  sample_valid,
    input  logic [bank_capture_pkg::sample_w-1:0] sample_data,
    bank_port_if.wr_src                           wr,
    output logic                                  overflow
);

    logic                                  have_low;
    logic [bank_capture_pkg::sample_w-1:0] low_byte;
    logic                                  trig_q;
    logic [bank_capture_pkg::word_w-1:0]   word_q;

    assign wr.trigger = trig_q;
    assign wr.data    = word_q;

    // ======================================================================
    // Pairing and overflow
    // ======================================================================
    always_ff @(posedge w_clk or posedge fullish) begin
        if (fullish) begin
            have_low <= 1'b0;
            trig_q   <= 1'b0;
            overflow <= 1'b0;
        end else begin
            // Second sample of a pair fires the write one cycle later
            trig_q <= sample_valid && have_low;
            if (sample_valid) begin
                have_low <= !have_low;
            end
            // Word refused by the FIFO is lost
            if (trig_q && !wr.ready) begin
                overflow <= 1'b1;
            end
        end
    end

    // First sample lands in the low byte
    always_ff @(posedge w_clk) begin
        if (sample_valid && !have_low) begin
            low_byte <= sample_data;
        end
        if (sample_valid && have_low) begin
            word_q <= {sample_data, low_byte};
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the bank_capture testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_bank_capture \
    -f bank_capture.f \
    -o sim_bank_capture

./obj_dir/sim_bank_capture | tee sim.log

if grep -qx 'TEST OK' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
